//--- common/vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

`define VGA_VMEM_WORDS 4096
`define VGA_CFG_AW 5
`define VGA_PAL_BASE 16

`define VGA_REG_MODE 0
`define VGA_REG_BITMASK 1
`define VGA_REG_HTOTAL 2
`define VGA_REG_HEND 3
`define VGA_REG_HSYNC_ST 4
`define VGA_REG_HSYNC_END 5
`define VGA_REG_VTOTAL 6
`define VGA_REG_VEND 7
`define VGA_REG_VSYNC_ST 8
`define VGA_REG_VSYNC_END 9
`define VGA_REG_START 10

`endif

//--- common/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // Bus and video memory data word
  typedef logic [15:0] word_t;

  // Word address into the on-chip video memory
  typedef logic [11:0] vmem_addr_t;

  // Raster operation code
  // 0 replace, 1 AND, 2 OR, 3 XOR
  typedef logic [1:0] rop_t;

  // Palette index, one pixel
  typedef logic [3:0] pixel_t;

  // Colour as {red, green, blue}, four bits each
  typedef logic [11:0] rgb_t;

  // Horizontal and vertical timing count
  typedef logic [9:0] crt_count_t;

  // Video memory arbiter states
  typedef enum logic [1:0] {
    IDLE,
    CPU_RD,
    CPU_WR,
    CPU_ACK
  } arb_state_e;

endpackage

`default_nettype wire

//--- hw/vga_config_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_params.svh"

module vga_config_regs (
  input  wire                    wb_clk_i,
  input  wire                    reset_i,
  input  wire                    cfg_stb_i,
  input  wire                    wb_we_i,
  input  wire [`VGA_CFG_AW-1:0]  cfg_adr_i,
  input  vga_pkg::word_t         wb_dat_i,
  input  vga_pkg::pixel_t        pal_idx_i,
  output vga_pkg::word_t         cfg_dat_o,
  output logic                   cfg_ack_o,
  output vga_pkg::rop_t          rop_o,
  output logic                   disp_en_o,
  output vga_pkg::word_t         bitmask_o,
  output vga_pkg::crt_count_t    htotal_o,
  output vga_pkg::crt_count_t    hend_o,
  output vga_pkg::crt_count_t    hsync_st_o,
  output vga_pkg::crt_count_t    hsync_end_o,
  output vga_pkg::crt_count_t    vtotal_o,
  output vga_pkg::crt_count_t    vend_o,
  output vga_pkg::crt_count_t    vsync_st_o,
  output vga_pkg::crt_count_t    vsync_end_o,
  output vga_pkg::vmem_addr_t    start_o,
  output vga_pkg::rgb_t          pal_rgb_o
);

  vga_pkg::rgb_t   pal_q [16];
  vga_pkg::pixel_t pal_sel;
  vga_pkg::word_t  rd_data;
  logic            is_pal;
  logic            wr_en;

  assign is_pal  = cfg_adr_i >= `VGA_PAL_BASE;
  assign pal_sel = vga_pkg::pixel_t'(cfg_adr_i - `VGA_CFG_AW'(`VGA_PAL_BASE));
  // Write only on the first cycle of the access, before the ack
  assign wr_en   = cfg_stb_i && wb_we_i && !cfg_ack_o;

  // Register read-back, narrow fields zero-extended
  always_comb begin
    rd_data = '0;
    if (is_pal) begin
      rd_data = 16'(pal_q[pal_sel]);
    end else begin
      case (cfg_adr_i)
        `VGA_REG_MODE:      rd_data = 16'({disp_en_o, rop_o});
        `VGA_REG_BITMASK:   rd_data = bitmask_o;
        `VGA_REG_HTOTAL:    rd_data = 16'(htotal_o);
        `VGA_REG_HEND:      rd_data = 16'(hend_o);
        `VGA_REG_HSYNC_ST:  rd_data = 16'(hsync_st_o);
        `VGA_REG_HSYNC_END: rd_data = 16'(hsync_end_o);
        `VGA_REG_VTOTAL:    rd_data = 16'(vtotal_o);
        `VGA_REG_VEND:      rd_data = 16'(vend_o);
        `VGA_REG_VSYNC_ST:  rd_data = 16'(vsync_st_o);
        `VGA_REG_VSYNC_END: rd_data = 16'(vsync_end_o);
        `VGA_REG_START:     rd_data = 16'(start_o);
        default:            rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      cfg_ack_o   <= 1'b0;
      rop_o       <= '0;
      disp_en_o   <= 1'b0;
      bitmask_o   <= '0;
      htotal_o    <= '0;
      hend_o      <= '0;
      hsync_st_o  <= '0;
      hsync_end_o <= '0;
      vtotal_o    <= '0;
      vend_o      <= '0;
      vsync_st_o  <= '0;
      vsync_end_o <= '0;
      start_o     <= '0;
    end else begin
      // One-cycle ack pulse per access
      cfg_ack_o <= cfg_stb_i && !cfg_ack_o;
      if (wr_en && !is_pal) begin
        case (cfg_adr_i)
          `VGA_REG_MODE: begin
            rop_o     <= wb_dat_i[1:0];
            disp_en_o <= wb_dat_i[2];
          end
          `VGA_REG_BITMASK:   bitmask_o   <= wb_dat_i;
          `VGA_REG_HTOTAL:    htotal_o    <= wb_dat_i[9:0];
          `VGA_REG_HEND:      hend_o      <= wb_dat_i[9:0];
          `VGA_REG_HSYNC_ST:  hsync_st_o  <= wb_dat_i[9:0];
          `VGA_REG_HSYNC_END: hsync_end_o <= wb_dat_i[9:0];
          `VGA_REG_VTOTAL:    vtotal_o    <= wb_dat_i[9:0];
          `VGA_REG_VEND:      vend_o      <= wb_dat_i[9:0];
          `VGA_REG_VSYNC_ST:  vsync_st_o  <= wb_dat_i[9:0];
          `VGA_REG_VSYNC_END: vsync_end_o <= wb_dat_i[9:0];
          `VGA_REG_START:     start_o     <= wb_dat_i[11:0];
          default: ;
        endcase
      end
    end
  end

  // Palette storage and read data for the bus
  always_ff @(posedge wb_clk_i) begin
    if (wr_en && is_pal) begin
      pal_q[pal_sel] <= wb_dat_i[11:0];
    end
    cfg_dat_o <= rd_data;
  end

  // Second read port for the pixel stage
  assign pal_rgb_o = pal_q[pal_idx_i];

endmodule

`default_nettype wire

//--- hw/vga_write_unit.sv
`timescale 1ns/10ps
`default_nettype none

module vga_write_unit (
  input  wire                  wb_clk_i,
  input  wire                  reset_i,
  input  wire                  mem_stb_i,
  input  wire                  wb_we_i,
  input  vga_pkg::vmem_addr_t  wb_adr_i,
  input  wire [1:0]            wb_sel_i,
  input  vga_pkg::word_t       wb_dat_i,
  input  vga_pkg::rop_t        rop_i,
  input  vga_pkg::word_t       bitmask_i,
  input  wire                  cpu_ack_i,
  input  vga_pkg::word_t       cpu_rdata_i,
  output vga_pkg::word_t       mem_dat_o,
  output logic                 mem_ack_o,
  output logic                 cpu_req_o,
  output logic                 cpu_we_o,
  output vga_pkg::vmem_addr_t  cpu_addr_o,
  output vga_pkg::word_t       cpu_wdata_o,
  output logic [1:0]           cpu_wsel_o
);

  vga_pkg::word_t latch_q;
  vga_pkg::word_t rop_res;

  // Raster operation of CPU data against the read latch
  always_comb begin
    case (rop_i)
      2'd1:    rop_res = wb_dat_i & latch_q;
      2'd2:    rop_res = wb_dat_i | latch_q;
      2'd3:    rop_res = wb_dat_i ^ latch_q;
      default: rop_res = wb_dat_i;
    endcase
  end

  // Masked bits keep the latched value
  assign cpu_wdata_o = (rop_res & bitmask_i) | (latch_q & ~bitmask_i);

  // Request stays up until the arbiter acks
  assign cpu_req_o  = mem_stb_i;
  assign cpu_we_o   = wb_we_i;
  assign cpu_addr_o = wb_adr_i;
  assign cpu_wsel_o = wb_sel_i;

  assign mem_ack_o = cpu_ack_i && mem_stb_i;
  assign mem_dat_o = cpu_rdata_i;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      latch_q <= '0;
    end else if (mem_ack_o && !wb_we_i) begin
      latch_q <= cpu_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/vga_mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_params.svh"

module vga_mem_arbiter (
  input  wire                  wb_clk_i,
  input  wire                  reset_i,
  input  wire                  fetch_i,
  input  vga_pkg::vmem_addr_t  fetch_addr_i,
  input  wire                  cpu_req_i,
  input  wire                  cpu_we_i,
  input  vga_pkg::vmem_addr_t  cpu_addr_i,
  input  vga_pkg::word_t       cpu_wdata_i,
  input  wire [1:0]            cpu_wsel_i,
  output vga_pkg::word_t       fetch_data_o,
  output vga_pkg::word_t       cpu_rdata_o,
  output logic                 cpu_ack_o
);

  vga_pkg::word_t     mem [`VGA_VMEM_WORDS];
  vga_pkg::arb_state_e state_q;

  // Display fetch always wins, CPU moves only in free cycles
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= vga_pkg::IDLE;
    end else begin
      case (state_q)
        vga_pkg::IDLE: begin
          if (cpu_req_i && !fetch_i) begin
            state_q <= cpu_we_i ? vga_pkg::CPU_WR : vga_pkg::CPU_RD;
          end
        end
        vga_pkg::CPU_RD,
        vga_pkg::CPU_WR: begin
          if (!fetch_i) begin
            state_q <= vga_pkg::CPU_ACK;
          end
        end
        default: state_q <= vga_pkg::IDLE;
      endcase
    end
  end

  // Single access per cycle into the array
  always_ff @(posedge wb_clk_i) begin
    if (fetch_i) begin
      fetch_data_o <= mem[fetch_addr_i];
    end else if (state_q == vga_pkg::CPU_RD) begin
      cpu_rdata_o <= mem[cpu_addr_i];
    end else if (state_q == vga_pkg::CPU_WR) begin
      if (cpu_wsel_i[0]) begin
        mem[cpu_addr_i][7:0] <= cpu_wdata_i[7:0];
      end
      if (cpu_wsel_i[1]) begin
        mem[cpu_addr_i][15:8] <= cpu_wdata_i[15:8];
      end
    end
  end

  assign cpu_ack_o = state_q == vga_pkg::CPU_ACK;

endmodule

`default_nettype wire

//--- display/vga_crtc.sv
`timescale 1ns/10ps
`default_nettype none

module vga_crtc (
  input  wire                  wb_clk_i,
  input  wire                  reset_i,
  input  wire                  disp_en_i,
  input  vga_pkg::crt_count_t  htotal_i,
  input  vga_pkg::crt_count_t  hend_i,
  input  vga_pkg::crt_count_t  hsync_st_i,
  input  vga_pkg::crt_count_t  hsync_end_i,
  input  vga_pkg::crt_count_t  vtotal_i,
  input  vga_pkg::crt_count_t  vend_i,
  input  vga_pkg::crt_count_t  vsync_st_i,
  input  vga_pkg::crt_count_t  vsync_end_i,
  input  vga_pkg::vmem_addr_t  start_i,
  output logic                 fetch_o,
  output vga_pkg::vmem_addr_t  fetch_addr_o,
  output logic                 blank_o,
  output logic                 hsync_o,
  output logic                 vsync_o
);

  vga_pkg::crt_count_t hcount_q;
  vga_pkg::crt_count_t vcount_q;
  logic                line_end;
  logic                frame_end;
  logic                active;
  logic                hsync_n;
  logic                vsync_n;
  logic [2:0]          hs_d;
  logic [2:0]          vs_d;
  logic [1:0]          blank_d;

  assign line_end  = hcount_q == htotal_i;
  assign frame_end = line_end && vcount_q == vtotal_i;
  assign active    = disp_en_i && hcount_q < hend_i && vcount_q < vend_i;

  // Active low syncs
  assign hsync_n = !(disp_en_i && hcount_q >= hsync_st_i && hcount_q < hsync_end_i);
  assign vsync_n = !(disp_en_i && vcount_q >= vsync_st_i && vcount_q < vsync_end_i);

  // One word holds four pixels
  assign fetch_o = active && hcount_q[1:0] == 2'b00;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i || !disp_en_i) begin
      hcount_q <= '0;
      vcount_q <= '0;
    end else if (line_end) begin
      hcount_q <= '0;
      vcount_q <= (vcount_q == vtotal_i) ? '0 : vcount_q + 1'b1;
    end else begin
      hcount_q <= hcount_q + 1'b1;
    end
  end

  // Frame restarts at the start address
  always_ff @(posedge wb_clk_i) begin
    if (reset_i || !disp_en_i || frame_end) begin
      fetch_addr_o <= start_i;
    end else if (fetch_o) begin
      fetch_addr_o <= fetch_addr_o + 1'b1;
    end
  end

  // Syncs take three stages to line up with RGB. Blank takes two here,
  // the colour register in the pixel stage is its third
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      hs_d    <= '1;
      vs_d    <= '1;
      blank_d <= '1;
    end else begin
      hs_d    <= {hs_d[1:0], hsync_n};
      vs_d    <= {vs_d[1:0], vsync_n};
      blank_d <= {blank_d[0], !active};
    end
  end

  assign hsync_o = hs_d[2];
  assign vsync_o = vs_d[2];
  assign blank_o = blank_d[1];

endmodule

`default_nettype wire

//--- display/vga_pixel_out.sv
`timescale 1ns/10ps
`default_nettype none

module vga_pixel_out (
  input  wire              wb_clk_i,
  input  wire              reset_i,
  input  wire              fetch_i,
  input  vga_pkg::word_t   fetch_data_i,
  input  vga_pkg::rgb_t    pal_rgb_i,
  input  wire              blank_i,
  output vga_pkg::pixel_t  pal_idx_o,
  output logic [3:0]       vga_red_o,
  output logic [3:0]       vga_green_o,
  output logic [3:0]       vga_blue_o
);

  logic           load_q;
  vga_pkg::word_t shift_q;
  vga_pkg::rgb_t  rgb_q;

  // Fetched word arrives the cycle after the fetch
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      load_q <= 1'b0;
      rgb_q  <= '0;
    end else begin
      load_q <= fetch_i;
      rgb_q  <= blank_i ? '0 : pal_rgb_i;
    end
  end

  // Top nibble is the current pixel
  always_ff @(posedge wb_clk_i) begin
    if (load_q) begin
      shift_q <= fetch_data_i;
    end else begin
      shift_q <= {shift_q[11:0], 4'h0};
    end
  end

  assign pal_idx_o   = shift_q[15:12];
  assign vga_red_o   = rgb_q[11:8];
  assign vga_green_o = rgb_q[7:4];
  assign vga_blue_o  = rgb_q[3:0];

endmodule

`default_nettype wire

//--- hw/vga.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_params.svh"

module vga (
  input  wire             wb_clk_i,
  input  wire             reset_i,
  input  vga_pkg::word_t  wb_dat_i,
  output vga_pkg::word_t  wb_dat_o,
  input  wire [11:0]      wb_adr_i,
  input  wire             wb_we_i,
  input  wire             wb_tga_i,
  input  wire [1:0]       wb_sel_i,
  input  wire             wb_stb_i,
  input  wire             wb_cyc_i,
  output logic            wb_ack_o,
  output logic [3:0]      vga_red_o,
  output logic [3:0]      vga_green_o,
  output logic [3:0]      vga_blue_o,
  output logic            hsync_o,
  output logic            vsync_o
);

  logic                stb;
  logic                cfg_stb;
  logic                mem_stb;
  vga_pkg::word_t      cfg_dat;
  logic                cfg_ack;
  vga_pkg::word_t      mem_dat;
  logic                mem_ack;

  vga_pkg::rop_t       rop;
  logic                disp_en;
  vga_pkg::word_t      bitmask;
  vga_pkg::crt_count_t htotal;
  vga_pkg::crt_count_t hend;
  vga_pkg::crt_count_t hsync_st;
  vga_pkg::crt_count_t hsync_end;
  vga_pkg::crt_count_t vtotal;
  vga_pkg::crt_count_t vend;
  vga_pkg::crt_count_t vsync_st;
  vga_pkg::crt_count_t vsync_end;
  vga_pkg::vmem_addr_t start;
  vga_pkg::pixel_t     pal_idx;
  vga_pkg::rgb_t       pal_rgb;

  logic                cpu_req;
  logic                cpu_we;
  vga_pkg::vmem_addr_t cpu_addr;
  vga_pkg::word_t      cpu_wdata;
  logic [1:0]          cpu_wsel;
  vga_pkg::word_t      cpu_rdata;
  logic                cpu_ack;

  logic                fetch;
  vga_pkg::vmem_addr_t fetch_addr;
  vga_pkg::word_t      fetch_data;
  logic                blank;

  // Address tag picks configuration or video memory
  assign stb     = wb_stb_i && wb_cyc_i;
  assign cfg_stb = stb && wb_tga_i;
  assign mem_stb = stb && !wb_tga_i;

  assign wb_dat_o = wb_tga_i ? cfg_dat : mem_dat;
  assign wb_ack_o = wb_tga_i ? cfg_ack : mem_ack;

  vga_config_regs u_config_regs (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .cfg_stb_i   (cfg_stb),
    .wb_we_i     (wb_we_i),
    .cfg_adr_i   (wb_adr_i[`VGA_CFG_AW-1:0]),
    .wb_dat_i    (wb_dat_i),
    .pal_idx_i   (pal_idx),
    .cfg_dat_o   (cfg_dat),
    .cfg_ack_o   (cfg_ack),
    .rop_o       (rop),
    .disp_en_o   (disp_en),
    .bitmask_o   (bitmask),
    .htotal_o    (htotal),
    .hend_o      (hend),
    .hsync_st_o  (hsync_st),
    .hsync_end_o (hsync_end),
    .vtotal_o    (vtotal),
    .vend_o      (vend),
    .vsync_st_o  (vsync_st),
    .vsync_end_o (vsync_end),
    .start_o     (start),
    .pal_rgb_o   (pal_rgb)
  );

  vga_write_unit u_write_unit (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .mem_stb_i   (mem_stb),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .rop_i       (rop),
    .bitmask_i   (bitmask),
    .cpu_ack_i   (cpu_ack),
    .cpu_rdata_i (cpu_rdata),
    .mem_dat_o   (mem_dat),
    .mem_ack_o   (mem_ack),
    .cpu_req_o   (cpu_req),
    .cpu_we_o    (cpu_we),
    .cpu_addr_o  (cpu_addr),
    .cpu_wdata_o (cpu_wdata),
    .cpu_wsel_o  (cpu_wsel)
  );

  vga_mem_arbiter u_mem_arbiter (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .fetch_i      (fetch),
    .fetch_addr_i (fetch_addr),
    .cpu_req_i    (cpu_req),
    .cpu_we_i     (cpu_we),
    .cpu_addr_i   (cpu_addr),
    .cpu_wdata_i  (cpu_wdata),
    .cpu_wsel_i   (cpu_wsel),
    .fetch_data_o (fetch_data),
    .cpu_rdata_o  (cpu_rdata),
    .cpu_ack_o    (cpu_ack)
  );

  vga_crtc u_crtc (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .disp_en_i    (disp_en),
    .htotal_i     (htotal),
    .hend_i       (hend),
    .hsync_st_i   (hsync_st),
    .hsync_end_i  (hsync_end),
    .vtotal_i     (vtotal),
    .vend_i       (vend),
    .vsync_st_i   (vsync_st),
    .vsync_end_i  (vsync_end),
    .start_i      (start),
    .fetch_o      (fetch),
    .fetch_addr_o (fetch_addr),
    .blank_o      (blank),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o)
  );

  vga_pixel_out u_pixel_out (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .fetch_i      (fetch),
    .fetch_data_i (fetch_data),
    .pal_rgb_i    (pal_rgb),
    .blank_i      (blank),
    .pal_idx_o    (pal_idx),
    .vga_red_o    (vga_red_o),
    .vga_green_o  (vga_green_o),
    .vga_blue_o   (vga_blue_o)
  );

endmodule

`default_nettype wire

//--- verification/vga_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "vga_params.svh"

module vga_tb;

  // Small display timing so a frame is short
  localparam vga_pkg::crt_count_t H_TOTAL = 10'd15;
  localparam vga_pkg::crt_count_t H_END   = 10'd8;
  localparam vga_pkg::crt_count_t HS_ST   = 10'd10;
  localparam vga_pkg::crt_count_t HS_END  = 10'd13;
  localparam vga_pkg::crt_count_t V_TOTAL = 10'd9;
  localparam vga_pkg::crt_count_t V_END   = 10'd6;
  localparam vga_pkg::crt_count_t VS_ST   = 10'd7;
  localparam vga_pkg::crt_count_t VS_END  = 10'd9;
  localparam int FRAME_CYCLES = (int'(H_TOTAL) + 1) * (int'(V_TOTAL) + 1);
  // One fetch per four active pixels
  localparam int FETCH_WORDS  = (int'(H_END) / 4) * int'(V_END);

  typedef struct {
    string          name;
    bit             cfg;
    bit             we;
    logic [11:0]    addr;
    vga_pkg::word_t data;
    logic [1:0]     sel;
    vga_pkg::word_t exp;
  } entry_t;

  logic                wb_clk_i = 1'b0;
  logic                reset_i;
  vga_pkg::word_t      wb_dat_i;
  vga_pkg::word_t      wb_dat_o;
  logic [11:0]         wb_adr_i;
  logic                wb_we_i;
  logic                wb_tga_i;
  logic [1:0]          wb_sel_i;
  logic                wb_stb_i;
  logic                wb_cyc_i;
  logic                wb_ack_o;
  logic [3:0]          vga_red_o;
  logic [3:0]          vga_green_o;
  logic [3:0]          vga_blue_o;
  logic                hsync_o;
  logic                vsync_o;

  entry_t              tbl [$];
  int                  seed = 12;
  vga_pkg::word_t      model_mem [`VGA_VMEM_WORDS];
  vga_pkg::word_t      model_latch;
  vga_pkg::word_t      model_mask;
  vga_pkg::rop_t       model_rop;
  vga_pkg::rgb_t       fill_colour;
  vga_pkg::crt_count_t timing_val [8];
  vga_pkg::word_t      rdata;
  vga_pkg::crt_count_t period;
  vga_pkg::crt_count_t low_width;

  vga uut (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_adr_i    (wb_adr_i),
    .wb_we_i     (wb_we_i),
    .wb_tga_i    (wb_tga_i),
    .wb_sel_i    (wb_sel_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_ack_o    (wb_ack_o),
    .vga_red_o   (vga_red_o),
    .vga_green_o (vga_green_o),
    .vga_blue_o  (vga_blue_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o)
  );

  always #10 wb_clk_i = ~wb_clk_i;

  function automatic vga_pkg::word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Raster operation against the latch
  function automatic vga_pkg::word_t raster(input vga_pkg::rop_t op, input vga_pkg::word_t d,
                                            input vga_pkg::word_t l);
    case (op)
      2'd1:    return d & l;
      2'd2:    return d | l;
      2'd3:    return d ^ l;
      default: return d;
    endcase
  endfunction

  task automatic add_entry(input string name, input bit cfg, input bit we,
                           input logic [11:0] addr, input vga_pkg::word_t data,
                           input logic [1:0] sel, input vga_pkg::word_t exp);
    entry_t e;
    e = '{name, cfg, we, addr, data, sel, exp};
    tbl.push_back(e);
  endtask

  task automatic cfg_write(input string name, input logic [11:0] idx,
                           input vga_pkg::word_t data);
    if (idx == 12'(`VGA_REG_MODE)) begin
      model_rop = data[1:0];
    end
    if (idx == 12'(`VGA_REG_BITMASK)) begin
      model_mask = data;
    end
    add_entry(name, 1'b1, 1'b1, idx, data, 2'b11, '0);
  endtask

  task automatic cfg_read(input string name, input logic [11:0] idx,
                          input vga_pkg::word_t exp);
    add_entry(name, 1'b1, 1'b0, idx, '0, 2'b11, exp);
  endtask

  // Bits under the mask take the raster result, the rest keep the latch
  task automatic mem_write(input string name, input vga_pkg::vmem_addr_t addr,
                           input vga_pkg::word_t data, input logic [1:0] sel);
    vga_pkg::word_t merged;
    merged = (raster(model_rop, data, model_latch) & model_mask) | (model_latch & ~model_mask);
    if (sel[0]) begin
      model_mem[addr][7:0] = merged[7:0];
    end
    if (sel[1]) begin
      model_mem[addr][15:8] = merged[15:8];
    end
    add_entry(name, 1'b0, 1'b1, addr, data, sel, '0);
  endtask

  task automatic mem_read(input string name, input vga_pkg::vmem_addr_t addr);
    model_latch = model_mem[addr];
    add_entry(name, 1'b0, 1'b0, addr, '0, 2'b11, model_latch);
  endtask

  task automatic build_table();
    int                  i;
    vga_pkg::word_t      w;
    vga_pkg::vmem_addr_t addrs [8];
    vga_pkg::vmem_addr_t start;
    vga_pkg::rgb_t       colour;
    vga_pkg::pixel_t     pix;
    model_rop   = '0;
    model_mask  = '0;
    model_latch = '0;
    timing_val  = '{H_TOTAL, H_END, HS_ST, HS_END, V_TOTAL, V_END, VS_ST, VS_END};
    // Register write and read-back
    for (i = 0; i < 8; i = i + 1) begin
      cfg_write($sformatf("timing %0d write", i), 12'(`VGA_REG_HTOTAL + i),
                {6'd0, timing_val[i]});
    end
    for (i = 0; i < 8; i = i + 1) begin
      cfg_read($sformatf("timing %0d read", i), 12'(`VGA_REG_HTOTAL + i),
               {6'd0, timing_val[i]});
    end
    w = rand_word();
    cfg_write("bitmask write", `VGA_REG_BITMASK, w);
    cfg_read("bitmask read", `VGA_REG_BITMASK, w);
    w = rand_word();
    colour = w[11:0];
    cfg_write("palette write", 12'(`VGA_PAL_BASE + 3), {4'h0, colour});
    cfg_read("palette read", 12'(`VGA_PAL_BASE + 3), {4'h0, colour});
    w = rand_word();
    start = w[11:0];
    cfg_write("start write", `VGA_REG_START, {4'h0, start});
    cfg_read("start read", `VGA_REG_START, {4'h0, start});
    // Plain writes then reads
    cfg_write("mode replace", `VGA_REG_MODE, 16'h0000);
    cfg_write("bitmask ones", `VGA_REG_BITMASK, 16'hffff);
    for (i = 0; i < 8; i = i + 1) begin
      w = rand_word();
      addrs[i] = w[11:0];
      w = rand_word();
      mem_write($sformatf("plain write %0d", i), addrs[i], w, 2'b11);
    end
    for (i = 0; i < 8; i = i + 1) begin
      mem_read($sformatf("plain read %0d", i), addrs[i]);
    end
    // AND, OR and XOR under a random mask
    for (i = 1; i < 4; i = i + 1) begin
      mem_read($sformatf("latch load %0d", i), addrs[i]);
      w = rand_word();
      cfg_write("random bitmask", `VGA_REG_BITMASK, w);
      cfg_write("raster mode", `VGA_REG_MODE, 16'(i));
      w = rand_word();
      mem_write("raster write", addrs[i], w, 2'b11);
      cfg_write("mode replace", `VGA_REG_MODE, 16'h0000);
      mem_read($sformatf("raster op %0d result", i), addrs[i]);
    end
    cfg_write("bitmask ones", `VGA_REG_BITMASK, 16'hffff);
    // Single byte writes
    for (i = 0; i < 2; i = i + 1) begin
      mem_read("byte latch", addrs[4 + i]);
      w = rand_word();
      mem_write("byte write", addrs[4 + i], w, 2'(i + 1));
      mem_read($sformatf("byte select %0d result", i + 1), addrs[4 + i]);
    end
    // Uniform picture for the colour check
    w = rand_word();
    pix = w[3:0];
    w = rand_word();
    fill_colour = w[11:0];
    for (i = 0; i < FETCH_WORDS; i = i + 1) begin
      mem_write("pattern fill", start + 12'(i), {4{pix}}, 2'b11);
    end
    cfg_write("fill colour", 12'(`VGA_PAL_BASE) + 12'(pix), {4'h0, fill_colour});
    cfg_write("display enable", `VGA_REG_MODE, 16'h0004);
  endtask

  // One Wishbone access, held until ack
  task automatic run_access(input entry_t e, output vga_pkg::word_t data);
    logic got;
    got = 1'b0;
    @(posedge wb_clk_i);
    wb_tga_i <= e.cfg;
    wb_we_i  <= e.we;
    wb_adr_i <= e.addr;
    wb_dat_i <= e.data;
    wb_sel_i <= e.sel;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    while (!got) begin
      @(negedge wb_clk_i);
      if (wb_ack_o) begin
        got = 1'b1;
        data = wb_dat_o;
      end
    end
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic check_word(input string name, input vga_pkg::word_t exp,
                            input vga_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_rgb(input string name, input vga_pkg::rgb_t exp,
                           input vga_pkg::rgb_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_period(input string name, input vga_pkg::crt_count_t exp,
                              input vga_pkg::crt_count_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // Returns on the first sample with the sync low
  task automatic wait_sync_fall(input bit vert);
    logic prev;
    logic cur;
    logic seen;
    @(negedge wb_clk_i);
    prev = vert ? vsync_o : hsync_o;
    seen = 1'b0;
    while (!seen) begin
      @(negedge wb_clk_i);
      cur = vert ? vsync_o : hsync_o;
      seen = prev && !cur;
      prev = cur;
    end
  endtask

  // Cycles from one falling edge to the next, and the low stretch
  task automatic measure_sync(input bit vert, output vga_pkg::crt_count_t cycles,
                              output vga_pkg::crt_count_t low);
    logic prev;
    logic cur;
    logic in_low;
    logic done;
    wait_sync_fall(vert);
    cycles = '0;
    low = 10'd1;
    prev = 1'b0;
    in_low = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge wb_clk_i);
      cycles = cycles + 10'd1;
      cur = vert ? vsync_o : hsync_o;
      if (cur) begin
        in_low = 1'b0;
      end else if (in_low) begin
        low = low + 10'd1;
      end
      done = prev && !cur;
      prev = cur;
    end
  endtask

  // Vsync falls at column 0 of line VS_ST, counts follow from there
  task automatic scan_frame();
    int                  n;
    vga_pkg::crt_count_t h;
    vga_pkg::crt_count_t v;
    logic                active;
    wait_sync_fall(1'b1);
    h = '0;
    v = VS_ST;
    for (n = 0; n < FRAME_CYCLES; n = n + 1) begin
      active = h < H_END && v < V_END;
      if (active) begin
        check_rgb("rgb in active video", fill_colour, {vga_red_o, vga_green_o, vga_blue_o});
      end else begin
        check_rgb("rgb in blank", '0, {vga_red_o, vga_green_o, vga_blue_o});
      end
      if (h == H_TOTAL) begin
        h = '0;
        v = (v == V_TOTAL) ? '0 : v + 10'd1;
      end else begin
        h = h + 10'd1;
      end
      @(negedge wb_clk_i);
    end
  endtask

  initial begin
    reset_i  = 1'b1;
    wb_dat_i = '0;
    wb_adr_i = '0;
    wb_we_i  = 1'b0;
    wb_tga_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    build_table();
    repeat (10) @(posedge wb_clk_i);
    reset_i <= 1'b0;
    foreach (tbl[i]) begin
      run_access(tbl[i], rdata);
      if (!tbl[i].we) begin
        check_word(tbl[i].name, tbl[i].exp, rdata);
      end
    end
    // Sync timing with the display running
    measure_sync(1'b0, period, low_width);
    check_period("hsync period", H_TOTAL + 10'd1, period);
    check_period("hsync low width", HS_END - HS_ST, low_width);
    measure_sync(1'b1, period, low_width);
    check_period("vsync period", vga_pkg::crt_count_t'(FRAME_CYCLES), period);
    check_period("vsync low width", (VS_END - VS_ST) * (H_TOTAL + 10'd1), low_width);
    scan_frame();
    $display("All tests passed!");
    $finish;
  end

  // Bus accesses plus a couple of frames for the display checks
  initial begin
    int limit;
    #1;
    limit = 10 + tbl.size() * 40 + 2 * FRAME_CYCLES;
    repeat (limit) @(posedge wb_clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Test failures found");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- vga.f
+incdir+common
common/vga_pkg.sv
hw/vga_config_regs.sv
hw/vga_write_unit.sv
hw/vga_mem_arbiter.sv
display/vga_crtc.sv
display/vga_pixel_out.sv
hw/vga.sv
verification/vga_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the VGA testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --timescale 1ns/10ps --top-module vga_tb -f vga.f -o vga_sim &&
./obj_dir/vga_sim > sim.log 2>&1 ||
echo "Build or simulation stopped early"
cat sim.log 2>/dev/null
! grep -q "Test failures found" sim.log && grep -q "All tests passed!" sim.log && echo PASS || { echo FAIL; exit 1; }
